//--- filelist.f
common/capture_pkg.sv
common/readout_pkg.sv
rtl/sample_decimator.sv
rtl/sample_packer.sv
rtl/capture_control.sv
sample_fifo/sample_fifo.sv
rtl/byte_serializer.sv
rtl/adc_capture_top.sv
testbench/tb_adc_capture_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status follows the run
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_adc_capture_top \
    -f filelist.f -o sim_tb &&
./obj_dir/sim_tb || { echo "simulation failed"; exit 1; }

//--- testbench/tb_adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_capture_top;

    localparam int FIFO_ADDR_W = 6;
    localparam int DS_W        = 13;
    localparam int DEPTH       = 1 << FIFO_ADDR_W;
    // Reset, pre-trigger, capture and readout of the three tests
    localparam int RUN_CYCLES  = (4 + 60 + 10 * 3 + 10 * 4) + (4 + 6 * 15 + 6 * 4) +
                                 (4 + (DEPTH + 1) * 3 + 20 + 8);
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + 200;

    logic                   adc_sampleclk;
    logic                   fifo_rst;
    logic [9:0]             adc_data_i;
    logic                   adc_or_i;
    logic                   arm_i;
    logic                   capture_go_i;
    logic                   stream_mode_i;
    logic [DS_W-1:0]        downsample_i;
    logic [FIFO_ADDR_W:0]   pre_words_i;
    logic [FIFO_ADDR_W:0]   max_words_i;
    logic                   read_en_i;
    wire  [7:0]             byte_o;
    wire                    byte_valid_o;
    wire                    fifo_empty_o;
    wire  [FIFO_ADDR_W:0]   words_o;
    wire                    capture_stop_o;
    wire                    overflow_o;

    capture_pkg::packed_word_t words_q[$];  // Reassembled words in read order
    logic [31:0]               asm_word;
    int                        byte_idx;
    int                        cycle_cnt = 0;
    logic                      hold_ovf;       // Overflow must stay up
    logic [9:0]                trig_code;      // Ramp code tagged at trigger

    adc_capture_top #(
        .FIFO_ADDR_W (FIFO_ADDR_W),
        .DS_W        (DS_W)
    ) i_adc_capture_top (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .adc_data_i     (adc_data_i),
        .adc_or_i       (adc_or_i),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .stream_mode_i  (stream_mode_i),
        .downsample_i   (downsample_i),
        .pre_words_i    (pre_words_i),
        .max_words_i    (max_words_i),
        .read_en_i      (read_en_i),
        .byte_o         (byte_o),
        .byte_valid_o   (byte_valid_o),
        .fifo_empty_o   (fifo_empty_o),
        .words_o        (words_o),
        .capture_stop_o (capture_stop_o),
        .overflow_o     (overflow_o)
    );

    initial begin
        adc_sampleclk = 1'b0;
        forever #20 adc_sampleclk = ~adc_sampleclk;        // 25 MHz
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string test, input int expected, input int actual);
        abort_run($sformatf("error %s: expected %0d, actual %0d", test, expected, actual));
    endtask

    always @(posedge adc_sampleclk) begin
        adc_data_i <= adc_data_i + 10'd1;                   // Ramp mod 1024
        cycle_cnt  <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // Byte reassembly and running checks, sampled mid-cycle
    always @(negedge adc_sampleclk) begin
        if (fifo_rst) begin
            byte_idx = 0;
        end else if (byte_valid_o) begin
            asm_word[8*byte_idx +: 8] = byte_o;             // Lowest byte arrives first
            if (byte_idx == 3) begin
                words_q.push_back(asm_word);
                byte_idx = 0;
            end else begin
                byte_idx = byte_idx + 1;
            end
        end
        if (!fifo_rst && !stream_mode_i && byte_valid_o) begin
            assert (capture_stop_o)
                else abort_run("byte_valid_o rose in normal mode before capture_stop_o");
        end
        if (hold_ovf) begin
            assert (overflow_o && capture_stop_o)
                else abort_run("overflow_o or capture_stop_o dropped before the arm edge");
        end
    end

    task automatic apply_reset(input logic stream, input int ds, input int pre,
                               input int max, input logic rd);
        @(posedge adc_sampleclk);
        fifo_rst      <= 1'b1;
        capture_go_i  <= 1'b0;
        stream_mode_i <= stream;
        downsample_i  <= DS_W'(ds);
        pre_words_i   <= (FIFO_ADDR_W+1)'(pre);
        max_words_i   <= (FIFO_ADDR_W+1)'(max);
        read_en_i     <= rd;                                // Held high, gated by the DUT
        repeat (4) @(posedge adc_sampleclk);
        fifo_rst <= 1'b0;
        words_q.delete();
    endtask

    // Tag position, tagged sample and ramp step over the read-out words
    task automatic check_words(input string test, input int n_words, input int pre,
                               input int step, input bit check_code, input logic [9:0] code);
        capture_pkg::packed_word_t w;
        logic [9:0]                smp [3];
        logic [9:0]                prev;
        int                        i;
        int                        k;
        assert (words_q.size() == n_words)
            else value_error({test, " word count"}, n_words, words_q.size());
        prev = '0;
        for (i = 0; i < n_words; i++) begin
            w      = words_q[i];
            smp[0] = w.sample0;                             // Oldest first
            smp[1] = w.sample1;
            smp[2] = w.sample2;
            if (i < pre) begin
                assert (w.trig_slot == 2'd3)
                    else value_error({test, " pre-trigger tag"}, 3, int'(w.trig_slot));
            end
            if (i == pre) begin
                assert (w.trig_slot != 2'd3)
                    else abort_run({test, ": first post-trigger word carries no tag"});
                if (check_code) begin
                    assert (smp[w.trig_slot] == code)
                        else value_error({test, " tagged sample"}, int'(code),
                                         int'(smp[w.trig_slot]));
                end
            end
            for (k = 0; k < 3; k++) begin
                if (i > 0 || k > 0) begin
                    assert (smp[k] == 10'(prev + step))
                        else value_error({test, " sample step"}, int'(10'(prev + step)),
                                         int'(smp[k]));
                end
                prev = smp[k];
            end
        end
    endtask

    initial begin
        fifo_rst      <= 1'b1;
        adc_data_i    <= '0;
        adc_or_i      <= 1'b0;
        arm_i         <= 1'b0;
        capture_go_i  <= 1'b0;
        stream_mode_i <= 1'b0;
        downsample_i  <= '0;
        pre_words_i   <= '0;
        max_words_i   <= '0;
        read_en_i     <= 1'b0;
        hold_ovf      = 1'b0;
        byte_idx      = 0;

        // Full rate, ring keeps 4 words, 10 in total
        apply_reset(1'b0, 0, 4, 10, 1'b1);
        repeat (60) @(posedge adc_sampleclk);               // About 20 words before trigger
        capture_go_i <= 1'b1;
        trig_code    = adc_data_i;                          // Code latched at this edge
        @(negedge adc_sampleclk);
        while (!capture_stop_o) @(negedge adc_sampleclk);
        assert (int'(words_o) == 10) else value_error("normal_ds0 words_o", 10, int'(words_o));
        while (!fifo_empty_o || byte_valid_o) @(negedge adc_sampleclk);
        check_words("normal_ds0", 10, 4, 1, 1'b1, trig_code);

        // Every fifth code, no pre-trigger words
        apply_reset(1'b0, 4, 0, 6, 1'b1);
        @(posedge adc_sampleclk);
        capture_go_i <= 1'b1;
        @(negedge adc_sampleclk);
        while (!capture_stop_o) @(negedge adc_sampleclk);
        assert (int'(words_o) == 6) else value_error("normal_ds4 words_o", 6, int'(words_o));
        while (!fifo_empty_o || byte_valid_o) @(negedge adc_sampleclk);
        check_words("normal_ds4", 6, 0, 5, 1'b0, '0);

        // Stream mode without reads fills past the depth
        apply_reset(1'b1, 0, 0, 0, 1'b0);
        @(posedge adc_sampleclk);
        capture_go_i <= 1'b1;
        @(negedge adc_sampleclk);
        while (!overflow_o) @(negedge adc_sampleclk);
        assert (capture_stop_o)
            else value_error("stream_ovf capture_stop_o", 1, int'(capture_stop_o));
        assert (int'(words_o) == DEPTH)
            else value_error("stream_ovf words_o", DEPTH, int'(words_o));
        hold_ovf = 1'b1;
        repeat (20) @(posedge adc_sampleclk);
        capture_go_i <= 1'b0;                               // No writes after the clear
        @(posedge adc_sampleclk);
        hold_ovf = 1'b0;
        arm_i    <= 1'b1;
        @(negedge adc_sampleclk);
        while (overflow_o) @(negedge adc_sampleclk);
        assert (!capture_stop_o)
            else value_error("stream_arm capture_stop_o", 0, int'(capture_stop_o));
        assert (fifo_empty_o)
            else value_error("stream_arm fifo_empty_o", 1, int'(fifo_empty_o));
        @(posedge adc_sampleclk);
        arm_i <= 1'b0;

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/adc_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module adc_capture_top #(
    parameter int FIFO_ADDR_W = 6,
    parameter int DS_W        = 13
) (
    input  wire                  adc_sampleclk,
    input  wire                  fifo_rst,
    input  wire  [9:0]           adc_data_i,
    input  wire                  adc_or_i,
    input  wire                  arm_i,
    input  wire                  capture_go_i,
    input  wire                  stream_mode_i,
    input  wire  [DS_W-1:0]      downsample_i,
    input  wire  [FIFO_ADDR_W:0] pre_words_i,
    input  wire  [FIFO_ADDR_W:0] max_words_i,
    input  wire                  read_en_i,
    output wire  [7:0]           byte_o,
    output wire                  byte_valid_o,
    output wire                  fifo_empty_o,
    output wire  [FIFO_ADDR_W:0] words_o,
    output wire                  capture_stop_o,
    output wire                  overflow_o
);

    wire                            sample_valid;
    wire capture_pkg::sample_t      sample;
    wire                            word_valid;
    wire capture_pkg::packed_word_t word;
    wire capture_pkg::packed_word_t head;
    wire readout_pkg::fifo_status_t fifo_status;
    wire                            wr_en;
    wire                            pop_drain;
    wire                            pop_read;
    wire                            fifo_pop;      // Drain or reader
    wire                            read_permit;
    wire                            clear;         // Arm edge

    assign fifo_pop     = pop_read || pop_drain;
    assign fifo_empty_o = fifo_status.empty;
    assign words_o      = fifo_status.count[FIFO_ADDR_W:0];

    sample_decimator #(
        .DS_W (DS_W)
    ) i_sample_decimator (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .adc_data_i     (adc_data_i),
        .adc_or_i       (adc_or_i),
        .capture_go_i   (capture_go_i),
        .downsample_i   (downsample_i),
        .sample_valid_o (sample_valid),
        .sample_o       (sample)
    );

    sample_packer i_sample_packer (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .capture_go_i   (capture_go_i),
        .sample_valid_i (sample_valid),
        .sample_i       (sample),
        .word_valid_o   (word_valid),
        .word_o         (word)
    );

    capture_control #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) i_capture_control (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .stream_mode_i  (stream_mode_i),
        .pre_words_i    (pre_words_i),
        .max_words_i    (max_words_i),
        .word_valid_i   (word_valid),
        .fifo_status_i  (fifo_status),
        .wr_en_o        (wr_en),
        .pop_drain_o    (pop_drain),
        .read_permit_o  (read_permit),
        .capture_stop_o (capture_stop_o),
        .overflow_o     (overflow_o),
        .clear_o        (clear)
    );

    sample_fifo #(
        .FIFO_ADDR_W (FIFO_ADDR_W)
    ) i_sample_fifo (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .clear_i       (clear),
        .wr_en_i       (wr_en),
        .wr_word_i     (word),
        .pop_i         (fifo_pop),
        .head_o        (head),
        .status_o      (fifo_status)
    );

    byte_serializer i_byte_serializer (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .clear_i       (clear),
        .read_en_i     (read_en_i),
        .read_permit_i (read_permit),
        .head_i        (head),
        .fifo_empty_i  (fifo_status.empty),
        .byte_o        (byte_o),
        .byte_valid_o  (byte_valid_o),
        .pop_o         (pop_read)
    );

endmodule

`default_nettype wire

//--- rtl/byte_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module byte_serializer (
    input  wire                            adc_sampleclk,
    input  wire                            fifo_rst,
    input  wire                            clear_i,
    input  wire                            read_en_i,
    input  wire                            read_permit_i,
    input  wire capture_pkg::packed_word_t head_i,
    input  wire                            fifo_empty_i,
    output logic [7:0]                     byte_o,
    output logic                           byte_valid_o,
    output logic                           pop_o
);

    readout_pkg::byte_slot_e slot;          // Byte presented next
    logic [31:0]             head_w;
    logic                    take;          // Byte transfer this cycle

    assign head_w = head_i;
    assign take   = read_en_i && read_permit_i && !fifo_empty_i;
    assign pop_o  = take && (slot == readout_pkg::BYTE3);     // Word fully sent

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || clear_i) begin
            slot         <= readout_pkg::BYTE0;
            byte_valid_o <= 1'b0;
        end else begin
            byte_valid_o <= take;
            if (take) begin
                slot <= readout_pkg::byte_slot_e'(slot + 2'd1);   // Wraps to BYTE0
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (take) begin
            case (slot)
                readout_pkg::BYTE0: byte_o <= head_w[7:0];        // Lowest first
                readout_pkg::BYTE1: byte_o <= head_w[15:8];
                readout_pkg::BYTE2: byte_o <= head_w[23:16];
                default:            byte_o <= head_w[31:24];
            endcase
        end
    end

    // A word partly sent is still held in the FIFO
    assert property (@(posedge adc_sampleclk) disable iff (fifo_rst || clear_i)
        (slot != readout_pkg::BYTE0) |-> !fifo_empty_i);

endmodule

`default_nettype wire

//--- sample_fifo/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter int FIFO_ADDR_W = 6
) (
    input  wire                            adc_sampleclk,
    input  wire                            fifo_rst,
    input  wire                            clear_i,
    input  wire                            wr_en_i,
    input  wire capture_pkg::packed_word_t wr_word_i,
    input  wire                            pop_i,
    output capture_pkg::packed_word_t      head_o,
    output readout_pkg::fifo_status_t      status_o
);

    localparam int DEPTH = 1 << FIFO_ADDR_W;

    capture_pkg::packed_word_t mem [DEPTH];
    logic [FIFO_ADDR_W-1:0]    wr_ptr;
    logic [FIFO_ADDR_W-1:0]    rd_ptr;
    logic [FIFO_ADDR_W:0]      count;       // One extra bit for full
    logic                      ovf;
    logic                      empty;
    logic                      full;
    logic                      do_wr;
    logic                      do_rd;

    assign empty = (count == '0);
    assign full  = (count == DEPTH[FIFO_ADDR_W:0]);
    assign do_wr = wr_en_i && !full;        // Write to full is lost
    assign do_rd = pop_i && !empty;         // Pop on empty ignored

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || clear_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
            if (wr_en_i && full) begin
                ovf <= 1'b1;                // Sticky until clear
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word_i;
        end
    end

    assign head_o = mem[rd_ptr];            // Fall-through head

    always_comb begin
        status_o                     = '0;
        status_o.empty               = empty;
        status_o.full                = full;
        status_o.overflow            = ovf;
        status_o.count[FIFO_ADDR_W:0] = count;
    end

    // Pointer distance tracks the occupancy count
    assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
        FIFO_ADDR_W'(wr_ptr - rd_ptr) == count[FIFO_ADDR_W-1:0]);

endmodule

`default_nettype wire

//--- rtl/capture_control.sv
`timescale 1ns/1ps
`default_nettype none

module capture_control #(
    parameter int FIFO_ADDR_W = 6
) (
    input  wire                             adc_sampleclk,
    input  wire                             fifo_rst,
    input  wire                             arm_i,
    input  wire                             capture_go_i,
    input  wire                             stream_mode_i,
    input  wire  [FIFO_ADDR_W:0]            pre_words_i,
    input  wire  [FIFO_ADDR_W:0]            max_words_i,
    input  wire                             word_valid_i,
    input  wire readout_pkg::fifo_status_t  fifo_status_i,
    output logic                            wr_en_o,
    output logic                            pop_drain_o,
    output logic                            read_permit_o,
    output logic                            capture_stop_o,
    output logic                            overflow_o,
    output logic                            clear_o
);

    capture_pkg::capture_state_e state_q;
    capture_pkg::capture_mode_e  mode;
    logic [1:0]                  arm_q;         // Arm history for edge detect
    logic                        rst_all;       // Reset or arm clear
    logic [FIFO_ADDR_W:0]        fifo_cnt;
    logic [FIFO_ADDR_W+1:0]      cnt_next;      // Count including pending write
    logic [FIFO_ADDR_W:0]        post_cnt;      // Words stored since trigger
    logic [FIFO_ADDR_W:0]        post_limit;
    logic                        done_hit;      // Post limit reached
    logic                        write_ok;

    assign mode       = capture_pkg::capture_mode_e'(stream_mode_i);
    assign rst_all    = fifo_rst || clear_o;
    assign fifo_cnt   = fifo_status_i.count[FIFO_ADDR_W:0];
    assign cnt_next   = {1'b0, fifo_cnt} + {{(FIFO_ADDR_W+1){1'b0}}, wr_en_o};
    assign post_limit = max_words_i - pre_words_i;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            arm_q   <= 2'b00;
            clear_o <= 1'b0;
        end else begin
            arm_q   <= {arm_q[0], arm_i};
            clear_o <= arm_q[0] && !arm_q[1];   // One pulse per arm rise
        end
    end

    assign done_hit = (mode == capture_pkg::MODE_NORMAL) &&
                      (state_q == capture_pkg::CAP_POST) && (post_cnt == post_limit);

    always_comb begin
        if (mode == capture_pkg::MODE_STREAM) begin
            write_ok = capture_go_i && (state_q != capture_pkg::CAP_DONE);
        end else begin
            write_ok = (state_q != capture_pkg::CAP_DONE) && !done_hit;
        end
    end

    assign wr_en_o = word_valid_i && write_ok;

    // Pop together with the write that would pass the pre-trigger limit,
    // so the count never exceeds pre_words_i at the trigger edge
    assign pop_drain_o = (mode == capture_pkg::MODE_NORMAL) &&
                         (state_q == capture_pkg::CAP_IDLE) &&
                         (cnt_next > {1'b0, pre_words_i});

    assign read_permit_o = (mode == capture_pkg::MODE_STREAM) ||
                           (state_q == capture_pkg::CAP_DONE);

    always_ff @(posedge adc_sampleclk) begin
        if (rst_all) begin
            state_q        <= capture_pkg::CAP_IDLE;
            post_cnt       <= '0;
            capture_stop_o <= 1'b0;
            overflow_o     <= 1'b0;
        end else begin
            overflow_o <= fifo_status_i.overflow;   // FIFO flag is already sticky
            case (state_q)
                capture_pkg::CAP_IDLE: begin
                    if (capture_go_i) begin
                        state_q <= capture_pkg::CAP_POST;
                    end
                end
                capture_pkg::CAP_POST: begin
                    if (done_hit || (mode == capture_pkg::MODE_STREAM &&
                                     fifo_status_i.overflow)) begin
                        state_q <= capture_pkg::CAP_DONE;
                    end
                end
                default: ;                          // Held until arm
            endcase
            if (state_q == capture_pkg::CAP_POST && wr_en_o) begin
                post_cnt <= post_cnt + 1'b1;
            end
            if (mode == capture_pkg::MODE_STREAM) begin
                capture_stop_o <= fifo_status_i.overflow;
            end else begin
                capture_stop_o <= done_hit || (state_q == capture_pkg::CAP_DONE);
            end
        end
    end

    // Pre-trigger ring never holds more than pre_words_i
    assert property (@(posedge adc_sampleclk) disable iff (rst_all)
        (!stream_mode_i && state_q == capture_pkg::CAP_IDLE) |-> (fifo_cnt <= pre_words_i));

    // A normal-mode stop holds until arm or reset
    assert property (@(posedge adc_sampleclk) disable iff (rst_all)
        (capture_stop_o && !stream_mode_i) |=> (capture_stop_o || stream_mode_i));

endmodule

`default_nettype wire

//--- rtl/sample_packer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_packer (
    input  wire                       adc_sampleclk,
    input  wire                       fifo_rst,
    input  wire                       capture_go_i,
    input  wire                       sample_valid_i,
    input  wire capture_pkg::sample_t sample_i,
    output logic                      word_valid_o,
    output capture_pkg::packed_word_t word_o
);

    logic [1:0] slot;                   // Next slot to fill, 0 to 2
    logic [1:0] trig_slot;              // Slot filling when trigger rose
    logic [9:0] smp0;
    logic [9:0] smp1;
    logic [9:0] smp2;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            slot         <= 2'd0;
            word_valid_o <= 1'b0;
        end else begin
            word_valid_o <= sample_valid_i && (slot == 2'd2);  // Word complete
            if (sample_valid_i) begin
                slot <= (slot == 2'd2) ? 2'd0 : slot + 2'd1;
            end
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (sample_valid_i) begin
            case (slot)
                2'd0:    smp0 <= sample_i.code;
                2'd1:    smp1 <= sample_i.code;
                default: smp2 <= sample_i.code;
            endcase
        end
    end

    // Tag holds the slot of the first triggered cycle until the trigger drops
    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || !capture_go_i) begin
            trig_slot <= capture_pkg::NO_TRIG_SLOT;
        end else if (trig_slot == capture_pkg::NO_TRIG_SLOT) begin
            trig_slot <= slot;
        end
    end

    assign word_o = '{trig_slot: trig_slot, sample2: smp2, sample1: smp1, sample0: smp0};

    assert property (@(posedge adc_sampleclk) disable iff (fifo_rst) slot != 2'd3);

endmodule

`default_nettype wire

//--- rtl/sample_decimator.sv
`timescale 1ns/1ps
`default_nettype none

module sample_decimator #(
    parameter int DS_W = 13
) (
    input  wire                  adc_sampleclk,
    input  wire                  fifo_rst,
    input  wire  [9:0]           adc_data_i,
    input  wire                  adc_or_i,
    input  wire                  capture_go_i,
    input  wire  [DS_W-1:0]      downsample_i,
    output logic                 sample_valid_o,
    output capture_pkg::sample_t sample_o
);

    logic [DS_W-1:0] ds_cnt;            // Cycles since last kept sample
    logic            ds_hit;            // Counter reached programmed ratio

    // A held counter still matches a zero ratio, so full-rate samples
    // keep flowing before the trigger
    assign ds_hit = (ds_cnt == downsample_i);

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || !capture_go_i) begin
            ds_cnt <= '0;               // Restart phase at trigger
        end else if (ds_hit) begin
            ds_cnt <= '0;
        end else begin
            ds_cnt <= ds_cnt + 1'b1;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            sample_valid_o <= 1'b0;
        end else begin
            sample_valid_o <= ds_hit;   // One per downsample_i+1 cycles
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (ds_hit) begin
            sample_o.code         <= adc_data_i;    // Skipped codes are dropped
            sample_o.out_of_range <= adc_or_i;
        end
    end

    // Non-zero ratio with the trigger low shuts the sample stream off
    assert property (@(posedge adc_sampleclk) disable iff (fifo_rst)
        !capture_go_i ##1 (!capture_go_i && downsample_i != '0) |=> !sample_valid_o);

endmodule

`default_nettype wire

//--- common/readout_pkg.sv
`default_nettype none

package readout_pkg;

    // Count field is sized for the largest FIFO, upper bits read as zero
    localparam int CNT_W = 16;

    typedef enum logic [1:0] {
        BYTE0 = 2'd0,                   // Bits 7:0, sent first
        BYTE1 = 2'd1,
        BYTE2 = 2'd2,
        BYTE3 = 2'd3                    // Bits 31:24, pops the word
    } byte_slot_e;

    typedef struct packed {
        logic             empty;
        logic             full;
        logic             overflow;     // Sticky until clear
        logic [CNT_W-1:0] count;        // Words held
    } fifo_status_t;

endpackage

`default_nettype wire

//--- common/capture_pkg.sv
`default_nettype none

package capture_pkg;

    typedef struct packed {
        logic       out_of_range;       // ADC overrange pin
        logic [9:0] code;               // Raw ADC code
    } sample_t;

    // Three samples per word, top two bits tag the trigger slot
    typedef struct packed {
        logic [1:0] trig_slot;          // Slot filling at trigger, 3 if none yet
        logic [9:0] sample2;            // Newest sample
        logic [9:0] sample1;
        logic [9:0] sample0;            // Oldest sample
    } packed_word_t;

    localparam logic [1:0] NO_TRIG_SLOT = 2'd3;    // Tag before capture starts

    typedef enum logic {
        MODE_NORMAL = 1'b0,             // Pre-trigger ring, read after stop
        MODE_STREAM = 1'b1              // No drain, host reads while capturing
    } capture_mode_e;

    typedef enum logic [1:0] {
        CAP_IDLE = 2'd0,                // Armed, keeping pre-trigger words
        CAP_POST = 2'd1,                // Counting post-trigger words
        CAP_DONE = 2'd2                 // Writes stopped
    } capture_state_e;

endpackage

`default_nettype wire
